// ==== dv/tb_typing.sv ====
`timescale 1ns/1ps

module tb_typing
    import typing_pkg::*;
();

    logic               clk;
    logic               reset;
    logic               ps2_clk;
    logic               ps2_data;
    judge_state_e       state;
    logic [count_w-1:0] correct_count;
    logic [count_w-1:0] miss_count;
    logic [idx_w-1:0]   article_index;

    // "the quick fox ok" as set-2 make codes
    logic [7:0] article_scan [article_len] = '{8'h2C, 8'h33, 8'h24, 8'h29, 8'h15, 8'h3C,
        8'h43, 8'h21, 8'h42, 8'h29, 8'h2B, 8'h44, 8'h22, 8'h29, 8'h44, 8'h42};

    judge_state_e       exp_state;   // reference model
    int                 exp_index;
    int                 exp_correct;
    int                 exp_miss;
    int                 errors;
    int                 bound_fails;
    int                 i;
    logic [31:0]        rng;
    logic [count_w-1:0] snap_correct;
    logic [count_w-1:0] snap_miss;

    typing_top i_dut (.*);

    always #20 clk = ~clk;

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #2;   // drive just after the edge
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // ==============================
    // PS/2 side
    // ==============================
    task automatic send_byte(input logic [7:0] b, input bit bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~^b ^ bad_parity, b, 1'b0};   // stop, odd parity, data, start
        for (int k = 0; k < 11; k++) begin
            ps2_data = frame[k];
            tick(6);
            ps2_clk = 1'b0;
            tick(6);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        tick(20);
    endtask

    function automatic logic [7:0] pick_wrong_key();
        logic [7:0] code;
        code = scan_ext;
        while (code == scan_ext || code == scan_break || code == article_scan[exp_index]) begin
            rng  = xorshift32(rng);
            code = rng[0] ? article_scan[rng[7:4]] : rng[15:8];   // wrong letter or junk
        end
        return code;
    endfunction

    task automatic take_snapshot();
        snap_correct = correct_count;
        snap_miss    = miss_count;
    endtask

    // wait for the score to move, or watch a window where nothing may move
    task automatic settle(input bit expect_change);
        int n;
        n = 0;
        if (expect_change) begin
            while (correct_count == snap_correct && miss_count == snap_miss && n < 1000) begin
                tick(1);
                n++;
            end
            if (n >= 1000) begin
                errors++;
                $display("timeout: no counter update after a key");
            end
        end else begin
            while (correct_count == snap_correct && miss_count == snap_miss && n < 60) begin
                tick(1);
                n++;
            end
        end
    endtask

    task automatic check_outputs();
        assert (state == exp_state) else begin
            errors++;
            $display("[FAIL] state: got %h expected %h", state, exp_state);
        end
        assert (article_index == idx_w'(exp_index)) else begin
            errors++;
            $display("[FAIL] article_index: got %h expected %h", article_index, exp_index);
        end
        assert (correct_count == count_w'(exp_correct)) else begin
            errors++;
            $display("[FAIL] correct_count: got %h expected %h", correct_count, exp_correct);
        end
        assert (miss_count == count_w'(exp_miss)) else begin
            errors++;
            $display("[FAIL] miss_count: got %h expected %h", miss_count, exp_miss);
        end
    endtask

    task automatic type_key(input logic [7:0] code);
        bit counted;
        take_snapshot();
        send_byte(code, 1'b0);
        counted = (exp_state != st_done);   // done keys are acked and ignored
        if (counted) begin
            exp_state = st_run;
            if (code == article_scan[exp_index]) begin
                exp_index++;
                exp_correct++;
                if (exp_index == article_len)
                    exp_state = st_done;
            end else
                exp_miss++;
        end
        settle(counted);
        check_outputs();
    endtask

    task automatic reset_dut();
        reset = 1'b1;
        tick(2);
        reset = 1'b0;
        exp_state   = st_idle;
        exp_index   = 0;
        exp_correct = 0;
        exp_miss    = 0;
        tick(1);
        check_outputs();
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        ps2_clk  = 1'b1;   // bus idle
        ps2_data = 1'b1;
        errors   = 0;
        rng      = 32'he031;
        reset_dut();

        for (i = 0; i < 3; i++)
            type_key(article_scan[exp_index]);
        for (i = 0; i < 8; i++)
            type_key(pick_wrong_key());

        // break and extended sequences are swallowed
        type_key(article_scan[exp_index]);
        take_snapshot();
        send_byte(scan_break, 1'b0);
        send_byte(article_scan[exp_index - 1], 1'b0);
        send_byte(scan_ext, 1'b0);
        send_byte(article_scan[exp_index], 1'b0);
        send_byte(scan_ext, 1'b0);
        send_byte(scan_break, 1'b0);
        send_byte(article_scan[exp_index], 1'b0);
        settle(1'b0);
        check_outputs();

        // bad parity frame is dropped and the retry counts
        take_snapshot();
        send_byte(article_scan[exp_index], 1'b1);
        settle(1'b0);
        check_outputs();
        type_key(article_scan[exp_index]);

        for (i = 0; i < article_len && exp_state != st_done; i++)
            type_key(article_scan[exp_index]);
        type_key(article_scan[0]);
        type_key(8'h1C);

        // restart from a mid-article reset
        reset_dut();
        for (i = 0; i < 5; i++)
            type_key(article_scan[exp_index]);
        reset_dut();
        for (i = 0; i < 3; i++)
            type_key(article_scan[exp_index]);

        bound_fails = i_dut.i_judge.i_judge_chk.fail_count
                    + i_dut.i_fifo.i_fifo_chk.fail_count;
        $display("checks failed: %0d, assertion failures: %0d", errors, bound_fails);
        if (errors == 0 && bound_fails == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== dv/typing_asserts.sv ====
`timescale 1ns/1ps

module typing_asserts
    import typing_pkg::*;
(
    input logic                            clk,
    input logic                            reset,
    input logic                            req,
    input logic                            ack,
    input logic [7:0]                      code,
    input logic [$clog2(fifo_depth+1)-1:0] fifo_count,
    input logic [count_w-1:0]              correct_count,
    input logic [count_w-1:0]              miss_count
);

    int fail_count = 0;   // read back by the testbench

    // ==============================
    // four-phase link
    // ==============================
    req_held: assert property (@(posedge clk) disable iff (reset)
        req && !ack |=> req)
        else begin
            $error("req dropped before ack");
            fail_count++;
        end

    code_stable: assert property (@(posedge clk) disable iff (reset)
        req && $past(req) |-> $stable(code))
        else begin
            $error("code changed while req high");
            fail_count++;
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req))
        else begin
            $error("ack raised without req");
            fail_count++;
        end

    // ==============================
    // counters and occupancy
    // ==============================
    score_up: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> correct_count >= $past(correct_count)
                          && miss_count >= $past(miss_count))
        else begin
            $error("score counter went down");
            fail_count++;
        end

    fifo_bound: assert property (@(posedge clk) disable iff (reset)
        fifo_count <= fifo_depth)
        else begin
            $error("key buffer count above depth");
            fail_count++;
        end

endmodule

// judge side checks the buffer-to-judge link
bind typing_judge typing_asserts i_judge_chk (
    .clk           (clk),
    .reset         (reset),
    .req           (in.req),
    .ack           (in.ack),
    .code          (in.code),
    .fifo_count    ('0),
    .correct_count (correct_count),
    .miss_count    (miss_count)
);

bind key_fifo typing_asserts i_fifo_chk (
    .clk           (clk),
    .reset         (reset),
    .req           (in.req),   // receiver-to-buffer link
    .ack           (in.ack),
    .code          (in.code),
    .fifo_count    (count),
    .correct_count ('0),
    .miss_count    ('0)
);

// ==== hdl/article_rom.sv ====
`timescale 1ns/1ps

module article_rom
    import typing_pkg::*;
(
    input  logic [idx_w-1:0] index,
    output char_t            ch
);

    // "the quick fox ok"
    always_comb begin
        case (index)
            5'd0:    ch = 6'd19;   // t
            5'd1:    ch = 6'd7;    // h
            5'd2:    ch = 6'd4;    // e
            5'd3:    ch = 6'd26;   // space
            5'd4:    ch = 6'd16;   // q
            5'd5:    ch = 6'd20;   // u
            5'd6:    ch = 6'd8;    // i
            5'd7:    ch = 6'd2;    // c
            5'd8:    ch = 6'd10;   // k
            5'd9:    ch = 6'd26;   // space
            5'd10:   ch = 6'd5;    // f
            5'd11:   ch = 6'd14;   // o
            5'd12:   ch = 6'd23;   // x
            5'd13:   ch = 6'd26;   // space
            5'd14:   ch = 6'd14;   // o
            5'd15:   ch = 6'd10;   // k
            default: ch = char_unknown;   // past the end
        endcase
    end

endmodule

// ==== hdl/key_fifo.sv ====
`timescale 1ns/1ps

module key_fifo
    import typing_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    key_if.consumer in,
    key_if.producer out
);

    logic [8:0]                      mem [fifo_depth];   // {tag, code}
    logic [$clog2(fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(fifo_depth)-1:0]   rd_ptr;
    logic [$clog2(fifo_depth+1)-1:0] count;
    logic                            full;
    logic                            empty;
    logic                            push;
    logic                            pop;
    logic                            load;

    assign full  = (count == fifo_depth);
    assign empty = (count == 0);

    assign push = in.req && !in.ack && !full;   // full holds ack back
    assign pop  = out.req && out.ack;
    assign load = !empty && !out.req && !out.ack;   // last exchange fully closed

    // ==============================
    // storage
    // ==============================
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= {in.tag, in.code};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + push - pop;
        end
    end

    // ==============================
    // handshakes
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            in.ack  <= 1'b0;
            out.req <= 1'b0;
        end else begin
            if (push)
                in.ack <= 1'b1;
            else if (in.ack && !in.req)
                in.ack <= 1'b0;

            if (load)
                out.req <= 1'b1;
            else if (pop)
                out.req <= 1'b0;
        end
    end

    // head entry is presented with req and held until the pop
    always_ff @(posedge clk) begin
        if (load)
            {out.tag, out.code} <= mem[rd_ptr];
    end

endmodule

// ==== hdl/key_if.sv ====
`timescale 1ns/1ps

// one key event on a four-phase req/ack link
interface key_if;

    logic       req;
    logic       ack;
    logic [7:0] code;   // make code, held while req is high
    logic       tag;    // event came from a parity-clean frame

    modport producer (
        output req, code, tag,
        input  ack
    );

    modport consumer (
        input  req, code, tag,
        output ack
    );

endinterface

// ==== hdl/ps2_rx.sv ====
`timescale 1ns/1ps

module ps2_rx
    import typing_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    ps2_clk,
    input  logic    ps2_data,
    key_if.producer out
);

    logic [1:0]  clk_sync;    // two-flop synchronizers
    logic [1:0]  data_sync;
    logic        clk_prev;
    logic        fall;
    logic [10:0] shift;
    logic [10:0] frame;
    logic [3:0]  bit_cnt;
    logic [11:0] idle_cnt;
    logic        frame_end;
    logic        frame_ok;
    logic [7:0]  rx_byte;
    logic        break_seen;
    logic        ext_seen;
    logic        send;

    // ==============================
    // sampling
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync  <= 2'b11;   // bus idles high
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign fall  = clk_prev & ~clk_sync[1];
    assign frame = {data_sync[1], shift[10:1]};   // lsb first so start ends up in bit 0

    always_ff @(posedge clk) begin
        if (fall)
            shift <= frame;
    end

    // bit counter resyncs if the line stalls mid-frame
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt  <= '0;
            idle_cnt <= '0;
        end else begin
            if (fall)
                bit_cnt <= frame_end ? 4'd0 : bit_cnt + 4'd1;
            else if (&idle_cnt)
                bit_cnt <= '0;
            if (fall || bit_cnt == 4'd0)
                idle_cnt <= '0;
            else if (!(&idle_cnt))
                idle_cnt <= idle_cnt + 12'd1;
        end
    end

    // ==============================
    // frame check and filter
    // ==============================
    assign frame_end = fall && (bit_cnt == 4'd10);
    assign frame_ok  = !frame[0] && frame[10] && (^frame[9:1]);   // start, stop, odd parity
    assign rx_byte   = frame[8:1];

    assign send = frame_end && frame_ok
               && rx_byte != scan_break && rx_byte != scan_ext
               && !break_seen && !ext_seen
               && !out.req && !out.ack;   // busy link drops the key

    always_ff @(posedge clk) begin
        if (reset) begin
            break_seen <= 1'b0;
            ext_seen   <= 1'b0;
        end else if (frame_end && frame_ok) begin
            if (rx_byte == scan_break)
                break_seen <= 1'b1;
            else if (rx_byte == scan_ext)
                ext_seen <= 1'b1;
            else begin
                // byte after a prefix is swallowed here
                break_seen <= 1'b0;
                ext_seen   <= 1'b0;
            end
        end
    end

    // producer side of the handshake
    always_ff @(posedge clk) begin
        if (reset)
            out.req <= 1'b0;
        else if (send)
            out.req <= 1'b1;
        else if (out.req && out.ack)
            out.req <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out.code <= rx_byte;
            out.tag  <= frame_ok;
        end
    end

endmodule

// ==== hdl/typing_judge.sv ====
`timescale 1ns/1ps

module typing_judge
    import typing_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    key_if.consumer            in,
    output judge_state_e       state,
    output logic [count_w-1:0] correct_count,
    output logic [count_w-1:0] miss_count,
    output logic [idx_w-1:0]   article_index
);

    char_t expect_ch;
    char_t key_ch;
    logic  take;
    logic  judge;
    logic  hit;
    logic  last_char;

    article_rom i_rom (
        .index (article_index),
        .ch    (expect_ch)
    );

    assign key_ch    = scan_to_char(in.code);
    assign take      = in.req && !in.ack;   // new event this cycle
    assign judge     = take && in.tag && (state != st_done);
    assign hit       = (key_ch == expect_ch);
    assign last_char = (article_index == idx_w'(article_len - 1));

    // ==============================
    // handshake
    // ==============================
    always_ff @(posedge clk) begin
        if (reset)
            in.ack <= 1'b0;
        else if (take)
            in.ack <= 1'b1;
        else if (in.ack && !in.req)
            in.ack <= 1'b0;
    end

    // ==============================
    // game FSM and scoring
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= st_idle;
            correct_count <= '0;
            miss_count    <= '0;
            article_index <= '0;
        end else if (judge) begin
            if (state == st_idle)
                state <= st_run;   // first key also counts below

            if (hit) begin
                article_index <= article_index + 1'b1;
                if (correct_count != '1)
                    correct_count <= correct_count + 1'b1;
                if (last_char)
                    state <= st_done;
            end else begin
                // wrong letter or unknown key
                if (miss_count != '1)
                    miss_count <= miss_count + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/typing_pkg.sv ====
package typing_pkg;

    // ==============================
    // sizes
    // ==============================
    localparam int article_len = 16;   // characters in the article
    localparam int idx_w       = 5;    // article index width
    localparam int fifo_depth  = 4;    // key buffer entries
    localparam int count_w     = 8;    // saturating score counters

    // set-2 prefix bytes
    localparam logic [7:0] scan_break = 8'hF0;
    localparam logic [7:0] scan_ext   = 8'hE0;

    // character code a..z = 0..25 and space = 26
    typedef logic [5:0] char_t;

    localparam char_t char_unknown = 6'd63;

    typedef enum logic [1:0] {
        st_idle = 2'd0,   // waiting for first key
        st_run  = 2'd1,   // article in progress
        st_done = 2'd2    // article finished
    } judge_state_e;

    // set-2 make code to character code
    function automatic char_t scan_to_char(input logic [7:0] code);
        case (code)
            8'h1C: return 6'd0;
            8'h32: return 6'd1;
            8'h21: return 6'd2;
            8'h23: return 6'd3;
            8'h24: return 6'd4;
            8'h2B: return 6'd5;
            8'h34: return 6'd6;
            8'h33: return 6'd7;
            8'h43: return 6'd8;
            8'h3B: return 6'd9;
            8'h42: return 6'd10;
            8'h4B: return 6'd11;
            8'h3A: return 6'd12;
            8'h31: return 6'd13;
            8'h44: return 6'd14;
            8'h4D: return 6'd15;
            8'h15: return 6'd16;
            8'h2D: return 6'd17;
            8'h1B: return 6'd18;
            8'h2C: return 6'd19;
            8'h3C: return 6'd20;
            8'h2A: return 6'd21;
            8'h1D: return 6'd22;
            8'h22: return 6'd23;
            8'h35: return 6'd24;
            8'h1A: return 6'd25;
            8'h29: return 6'd26;  // space
            default: return char_unknown;
        endcase
    endfunction

endpackage

// ==== hdl/typing_top.sv ====
`timescale 1ns/1ps

module typing_top
    import typing_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               ps2_clk,
    input  logic               ps2_data,
    output judge_state_e       state,
    output logic [count_w-1:0] correct_count,
    output logic [count_w-1:0] miss_count,
    output logic [idx_w-1:0]   article_index
);

    key_if kin ();    // receiver to buffer
    key_if kout ();   // buffer to judge

    ps2_rx i_rx (
        .clk      (clk),
        .reset    (reset),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .out      (kin.producer)
    );

    key_fifo i_fifo (
        .clk   (clk),
        .reset (reset),
        .in    (kin.consumer),
        .out   (kout.producer)
    );

    typing_judge i_judge (
        .clk           (clk),
        .reset         (reset),
        .in            (kout.consumer),
        .state         (state),
        .correct_count (correct_count),
        .miss_count    (miss_count),
        .article_index (article_index)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_typing -Mdir obj_dir

# keep running past assertion errors so the testbench prints its verdict
out=$(./obj_dir/Vtb_typing +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -q "^RESULT: PASS$"

// ==== sim.f ====
hdl/typing_pkg.sv
hdl/key_if.sv
hdl/ps2_rx.sv
hdl/key_fifo.sv
hdl/article_rom.sv
hdl/typing_judge.sv
hdl/typing_top.sv
dv/typing_asserts.sv
dv/tb_typing.sv
